/* source/jump_pkg.sv */
package jump_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int phy_w     = 17;  // signed physics word
    localparam int frac_bits = 8;   // velocity fraction bits

    // --------------------
    // map geometry
    // --------------------
    localparam logic signed [phy_w-1:0] x_min   = 17'sd180;  // right wall + wall width
    localparam logic signed [phy_w-1:0] x_max   = 17'sd538;  // left wall 580 - char width 42
    localparam logic signed [phy_w-1:0] floor_y = 17'sd20;
    localparam logic signed [phy_w-1:0] init_x  = 17'sd517;
    localparam logic signed [phy_w-1:0] init_y  = 17'sd770;

    // --------------------
    // physics constants
    // --------------------
    localparam logic signed [phy_w-1:0] gravity    = -17'sd256;   // one pixel per step per step
    localparam logic signed [phy_w-1:0] max_vel    = phy_w'(58 << frac_bits);
    localparam logic signed [phy_w-1:0] jump_vel_x = 17'sd512;
    localparam logic signed [phy_w-1:0] jump_vel_y = 17'sd1536;

    // charge counter limits
    localparam logic [15:0] max_charge  = 16'd500;
    localparam logic [15:0] charge_step = 16'd10;

    // --------------------
    // movement state codes
    // --------------------
    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_left   = 3'd1;
    localparam logic [2:0] st_right  = 3'd2;
    localparam logic [2:0] st_charge = 3'd3;
    localparam logic [2:0] st_jump   = 3'd4;

    // raw button levels
    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } buttons_t;

    // position and velocity with frac_bits of velocity fraction
    typedef struct packed {
        logic signed [phy_w-1:0] pos_x;
        logic signed [phy_w-1:0] pos_y;
        logic signed [phy_w-1:0] vel_x;
        logic signed [phy_w-1:0] vel_y;
    } motion_t;

    // registered wall contact flags
    typedef struct packed {
        logic on_ground;
        logic at_left;
        logic at_right;
    } contact_t;

endpackage

/* source/move_controller.sv */
module move_controller (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               move_tick,
    input  jump_pkg::buttons_t buttons,
    input  logic               on_ground,
    output logic               step,
    output logic [2:0]         char_state,
    output logic [15:0]        jump_cnt
);

    jump_pkg::buttons_t btn_q;        // registered button levels
    logic               jump_req;     // pending jump press seen on ground
    logic               charge_full;
    logic [2:0]         next_state;

    // --------------------
    // input sampling
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step  <= 1'b0;
            btn_q <= '0;
        end else begin
            step  <= move_tick;  // one cycle behind the tick
            btn_q <= buttons;
        end
    end

    // rising edge of jump while standing arms a charge
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_req <= 1'b0;
        end else if (buttons.jump && !btn_q.jump && on_ground) begin
            jump_req <= 1'b1;
        end else if (char_state == jump_pkg::st_jump) begin
            jump_req <= 1'b0;
        end
    end

    assign charge_full = (jump_cnt >= jump_pkg::max_charge);

    // --------------------
    // movement FSM
    // --------------------
    always_comb begin
        case (char_state)
            jump_pkg::st_idle, jump_pkg::st_left, jump_pkg::st_right: begin
                if (!on_ground) begin
                    next_state = jump_pkg::st_idle;  // no control in the air
                end else if (btn_q.left) begin
                    next_state = jump_pkg::st_left;
                end else if (btn_q.right) begin
                    next_state = jump_pkg::st_right;
                end else if (jump_req) begin
                    next_state = jump_pkg::st_charge;
                end else begin
                    next_state = jump_pkg::st_idle;
                end
            end
            jump_pkg::st_charge: begin
                // release or full charge launches
                if (!btn_q.jump || charge_full) begin
                    next_state = jump_pkg::st_jump;
                end else begin
                    next_state = jump_pkg::st_charge;
                end
            end
            default: begin
                next_state = jump_pkg::st_idle;  // jump lasts one step
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_state <= jump_pkg::st_idle;
        end else if (step) begin
            char_state <= next_state;
        end
    end

    // charge grows while held and drops back to 1 once launched
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_cnt <= 16'd1;
        end else if (step) begin
            if (char_state == jump_pkg::st_charge) begin
                jump_cnt <= jump_cnt + jump_pkg::charge_step;
            end else if (char_state == jump_pkg::st_jump) begin
                jump_cnt <= 16'd1;
            end
        end
    end

endmodule

/* source/boundary_detector.sv */
module boundary_detector (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  jump_pkg::motion_t  motion,
    output jump_pkg::contact_t contact
);

    logic signed [jump_pkg::phy_w-1:0] px;
    logic signed [jump_pkg::phy_w-1:0] py;

    assign px = motion.pos_x;
    assign py = motion.pos_y;

    // --------------------
    // contact flags
    // --------------------
    // position is always clamped, so equality is enough
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            contact <= '0;
        end else begin
            contact.on_ground <= (py == jump_pkg::floor_y);
            contact.at_left   <= (px == jump_pkg::x_max);  // left is +x
            contact.at_right  <= (px == jump_pkg::x_min);
        end
    end

endmodule

/* source/motion_integrator.sv */
module motion_integrator (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   step,
    input  logic [2:0]             char_state,
    input  logic [15:0]            jump_cnt,
    input  jump_pkg::contact_t     contact,
    output jump_pkg::motion_t      motion,
    output logic signed [1:0]      face
);

    logic signed [jump_pkg::phy_w-1:0] jump_factor;
    logic signed [jump_pkg::phy_w-1:0] imp_x;        // horizontal launch speed
    logic signed [jump_pkg::phy_w-1:0] walk;
    logic signed [jump_pkg::phy_w-1:0] vx;
    logic signed [jump_pkg::phy_w-1:0] vy;
    logic signed [jump_pkg::phy_w-1:0] px;
    logic signed [jump_pkg::phy_w-1:0] py;
    logic signed [1:0]                 face_nxt;
    logic                              into_wall;
    jump_pkg::motion_t                 motion_nxt;

    function automatic logic signed [jump_pkg::phy_w-1:0] clamp_vel(
        input logic signed [jump_pkg::phy_w-1:0] v
    );
        if (v > jump_pkg::max_vel) begin
            return jump_pkg::max_vel;
        end else if (v < -jump_pkg::max_vel) begin
            return -jump_pkg::max_vel;
        end
        return v;
    endfunction

    // charge bits mapped onto a launch speed of 32 to 2496
    assign jump_factor = $signed({6'd0, jump_cnt[8:6], 8'd0})
                       + $signed({8'd0, jump_cnt[5:3], 6'd0})
                       + $signed({9'd0, jump_cnt[2:0], 5'd0})
                       + 17'sd32;

    assign imp_x = jump_pkg::jump_vel_x + (jump_factor >>> 2);

    // --------------------
    // next motion
    // --------------------
    always_comb begin
        vx = motion.vel_x;
        vy = motion.vel_y;
        px = motion.pos_x;
        py = motion.pos_y;
        face_nxt = face;

        // side wall hit in the air reverses direction
        into_wall = !contact.on_ground
                  && ((contact.at_left && vx > 0) || (contact.at_right && vx < 0));
        if (into_wall) begin
            vx = -vx;
            face_nxt = -face;
        end else if (char_state == jump_pkg::st_left) begin
            face_nxt = 2'sd1;
        end else if (char_state == jump_pkg::st_right) begin
            face_nxt = -2'sd1;
        end

        if (char_state == jump_pkg::st_jump) begin
            vx = face_nxt[1] ? vx - imp_x : vx + imp_x;  // face is +1 or -1
            vy = vy + jump_pkg::jump_vel_y + jump_factor;
        end

        if (!contact.on_ground) begin
            vy = vy + jump_pkg::gravity;
        end

        vx = clamp_vel(vx);
        vy = clamp_vel(vy);

        // one pixel per walking step
        if (char_state == jump_pkg::st_left) begin
            walk = 17'sd1;
        end else if (char_state == jump_pkg::st_right) begin
            walk = -17'sd1;
        end else begin
            walk = 17'sd0;
        end
        px = px + walk + (vx >>> jump_pkg::frac_bits);
        py = py + (vy >>> jump_pkg::frac_bits);

        if (px < jump_pkg::x_min) begin
            px = jump_pkg::x_min;
        end else if (px > jump_pkg::x_max) begin
            px = jump_pkg::x_max;
        end

        if (py < jump_pkg::floor_y) begin  // landing
            py = jump_pkg::floor_y;
            vx = '0;
            vy = '0;
        end

        motion_nxt.pos_x = px;
        motion_nxt.pos_y = py;
        motion_nxt.vel_x = vx;
        motion_nxt.vel_y = vy;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            motion.pos_x <= jump_pkg::init_x;
            motion.pos_y <= jump_pkg::init_y;
            motion.vel_x <= '0;
            motion.vel_y <= '0;
            face         <= 2'sd1;  // facing left
        end else if (step) begin
            motion <= motion_nxt;
            face   <= face_nxt;
        end
    end

endmodule

/* source/jump_character.sv */
module jump_character (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               move_tick,
    input  jump_pkg::buttons_t buttons,
    output jump_pkg::motion_t  motion,
    output logic signed [1:0]  face,
    output logic [15:0]        jump_cnt,
    output logic               on_ground
);

    logic               step;
    logic [2:0]         char_state;
    jump_pkg::contact_t contact;

    // --------------------
    // control and contact side by side
    // --------------------
    move_controller i_move_controller (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .move_tick  (move_tick),
        .buttons    (buttons),
        .on_ground  (contact.on_ground),
        .step       (step),
        .char_state (char_state),
        .jump_cnt   (jump_cnt)
    );

    boundary_detector i_boundary_detector (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .motion    (motion),
        .contact   (contact)
    );

    // integrator merges both results
    motion_integrator i_motion_integrator (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .step       (step),
        .char_state (char_state),
        .jump_cnt   (jump_cnt),
        .contact    (contact),
        .motion     (motion),
        .face       (face)
    );

    assign on_ground = contact.on_ground;

endmodule

/* testbench/tb_jump_character.sv */
module tb_jump_character;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        jump_pkg::buttons_t btn;
        int                 steps;
        int                 exp_x;       // -1 skips the end-of-row check
        int                 exp_cnt;
        int                 exp_ground;
    } row_t;

    logic               sys_clk;
    logic               sys_rst_n;
    logic               move_tick;
    jump_pkg::buttons_t buttons;
    jump_pkg::motion_t  motion;
    logic signed [1:0]  face;
    logic [15:0]        jump_cnt;
    logic               on_ground;

    row_t        stim_rows[$];
    logic [31:0] lcg_state = 32'hfdb7_0b7f;

    // --------------------
    // reference model state
    // --------------------
    int         m_px   = int'(jump_pkg::init_x);
    int         m_py   = int'(jump_pkg::init_y);
    int         m_vx   = 0;
    int         m_vy   = 0;
    int         m_face = 1;
    int         m_cnt  = 1;
    logic [2:0] m_state = jump_pkg::st_idle;
    logic       m_req = 1'b0;
    logic       m_prev_jump = 1'b0;
    int         bounce_cnt = 0;
    int         forced_cnt = 0;

    jump_character i_dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .move_tick (move_tick),
        .buttons   (buttons),
        .motion    (motion),
        .face      (face),
        .jump_cnt  (jump_cnt),
        .on_ground (on_ground)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (4) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_cycles(input int n);
        int count;
        count = 0;
        while (count < n) begin
            @(posedge sys_clk);
            count++;
            if (count > 64) begin
                $display("a wait of %0d cycles ran past its limit", n);
                abort_run();
            end
        end
        #1;  // sample and drive just after the edge
    endtask

    task automatic wait_reset_release();
        int count;
        count = 0;
        while (sys_rst_n !== 1'b1) begin
            @(posedge sys_clk);
            count++;
            if (count > 20) begin
                $display("reset was never released");
                abort_run();
            end
        end
    endtask

    task automatic pulse_tick();
        @(posedge sys_clk);
        #1 move_tick = 1'b1;
        @(posedge sys_clk);
        #1 move_tick = 1'b0;
    endtask

    function automatic int next_gap();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return 2 + int'(lcg_state[19:16]);
    endfunction

    task automatic add_row(input logic l, r, j, input int steps, x, cnt, gnd);
        row_t row;
        row.btn.left   = l;
        row.btn.right  = r;
        row.btn.jump   = j;
        row.steps      = steps;
        row.exp_x      = x;
        row.exp_cnt    = cnt;
        row.exp_ground = gnd;
        stim_rows.push_back(row);
    endtask

    task automatic apply_buttons(input jump_pkg::buttons_t b);
        if (b.jump && !m_prev_jump && m_py == int'(jump_pkg::floor_y)
                && m_state != jump_pkg::st_jump) begin
            m_req = 1'b1;  // fresh press on the floor
        end
        m_prev_jump = b.jump;
        buttons = b;
    endtask

    // one motion step with contact taken from the position before it
    task automatic advance_model(input jump_pkg::buttons_t b);
        logic       gnd;
        logic       at_l;
        logic       at_r;
        logic [2:0] nxt;
        int         jf;
        int         vmax;
        gnd  = (m_py == int'(jump_pkg::floor_y));
        at_l = (m_px == int'(jump_pkg::x_max));
        at_r = (m_px == int'(jump_pkg::x_min));
        vmax = int'(jump_pkg::max_vel);
        if (m_state == jump_pkg::st_charge) begin
            if (b.jump && m_cnt >= int'(jump_pkg::max_charge)) forced_cnt++;
            nxt = (!b.jump || m_cnt >= int'(jump_pkg::max_charge)) ? jump_pkg::st_jump
                                                                   : jump_pkg::st_charge;
        end else if (m_state == jump_pkg::st_jump || !gnd) nxt = jump_pkg::st_idle;
        else if (b.left) nxt = jump_pkg::st_left;
        else if (b.right) nxt = jump_pkg::st_right;
        else if (m_req) nxt = jump_pkg::st_charge;
        else nxt = jump_pkg::st_idle;
        if (!gnd && ((at_l && m_vx > 0) || (at_r && m_vx < 0))) begin
            m_vx = -m_vx;
            m_face = -m_face;
            bounce_cnt++;
        end else if (m_state == jump_pkg::st_left) m_face = 1;
        else if (m_state == jump_pkg::st_right) m_face = -1;
        jf = ((m_cnt >> 6) % 8) * 256 + ((m_cnt >> 3) % 8) * 64 + (m_cnt % 8) * 32 + 32;
        if (m_state == jump_pkg::st_jump) begin
            m_vx += (int'(jump_pkg::jump_vel_x) + (jf >>> 2)) * m_face;
            m_vy += int'(jump_pkg::jump_vel_y) + jf;
        end
        if (!gnd) m_vy += int'(jump_pkg::gravity);
        m_vx = (m_vx > vmax) ? vmax : ((m_vx < -vmax) ? -vmax : m_vx);
        m_vy = (m_vy > vmax) ? vmax : ((m_vy < -vmax) ? -vmax : m_vy);
        if (m_state == jump_pkg::st_left) m_px += 1;
        else if (m_state == jump_pkg::st_right) m_px -= 1;
        m_px += m_vx >>> jump_pkg::frac_bits;
        m_py += m_vy >>> jump_pkg::frac_bits;
        if (m_px < int'(jump_pkg::x_min)) m_px = int'(jump_pkg::x_min);
        else if (m_px > int'(jump_pkg::x_max)) m_px = int'(jump_pkg::x_max);
        if (m_py < int'(jump_pkg::floor_y)) begin  // landing
            m_py = int'(jump_pkg::floor_y);
            m_vx = 0;
            m_vy = 0;
        end
        if (m_state == jump_pkg::st_charge) m_cnt += int'(jump_pkg::charge_step);
        else if (m_state == jump_pkg::st_jump) m_cnt = 1;
        m_state = nxt;
        if (m_state == jump_pkg::st_jump) m_req = 1'b0;
    endtask

    task automatic check_outputs(input string tag);
        check_value({tag, " pos_x"}, int'($signed(motion.pos_x)), m_px);
        check_value({tag, " pos_y"}, int'($signed(motion.pos_y)), m_py);
        check_value({tag, " vel_x"}, int'($signed(motion.vel_x)), m_vx);
        check_value({tag, " vel_y"}, int'($signed(motion.vel_y)), m_vy);
        check_value({tag, " face"}, int'(face), m_face);
        check_value({tag, " jump_cnt"}, int'(jump_cnt), m_cnt);
        check_value({tag, " on_ground"}, int'(on_ground), int'(m_py == int'(jump_pkg::floor_y)));
    endtask

    initial begin
        row_t  row;
        int    gap;
        string tag;
        move_tick = 1'b0;
        buttons   = '0;
        // left right jump  steps  end x  end cnt  end ground
        add_row(0, 0, 0,  40, 517,  1, 1);  // free fall and landing
        add_row(1, 0, 0,  25, 538,  1, 1);  // walk to x_max
        add_row(0, 1, 0, 362, 180,  1, 1);  // walk to x_min
        add_row(1, 0, 0,  30, 209,  1, 1);
        add_row(0, 0, 0,   2, 210,  1, 1);
        add_row(0, 0, 1,  10, 210, 91, 1);  // charge
        add_row(0, 0, 0,  25, 246,  1, 1);  // release, jump, land
        add_row(0, 0, 1, 100, 374,  1, 1);  // forced launch at full charge
        add_row(0, 0, 0,   3, 374,  1, 1);
        add_row(1, 0, 0, 200, 538,  1, 1);
        add_row(0, 0, 0,   2, 538,  1, 1);
        add_row(0, 0, 1,   3, 538, 21, 1);
        add_row(0, 0, 0,  30, 493,  1, 1);  // jump into the wall, bounce back
        wait_reset_release();
        wait_cycles(2);
        check_outputs("after reset");
        foreach (stim_rows[i]) begin
            row = stim_rows[i];
            apply_buttons(row.btn);
            gap = next_gap();
            wait_cycles(gap);
            for (int s = 0; s < row.steps; s++) begin
                pulse_tick();
                wait_cycles(8);
                advance_model(row.btn);
                tag = $sformatf("row %0d step %0d", i, s);
                check_outputs(tag);
            end
            tag = $sformatf("row %0d end", i);
            if (row.exp_x >= 0) begin
                check_value({tag, " pos_x"}, int'($signed(motion.pos_x)), row.exp_x);
            end
            if (row.exp_cnt >= 0) begin
                check_value({tag, " jump_cnt"}, int'(jump_cnt), row.exp_cnt);
            end
            if (row.exp_ground >= 0) begin
                check_value({tag, " on_ground"}, int'(on_ground), row.exp_ground);
            end
        end
        check_value("wall bounces", bounce_cnt, 1);
        check_value("forced launches", forced_cnt, 1);
        $display("** PASS **");
        $finish;
    end

endmodule

/* jump_character.f */
source/jump_pkg.sv
source/move_controller.sv
source/boundary_detector.sv
source/motion_integrator.sv
source/jump_character.sv
testbench/tb_jump_character.sv

/* Makefile */
TOP := tb_jump_character

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f jump_character.f

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --top-module $(TOP) -f jump_character.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
